// File: source/link_pkg.sv
`default_nettype none

package link_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Serial line timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int CLKS_PER_BIT = 16; // Clocks per serial bit.

	// Idle bit times after the last stop bit that close a frame.
	localparam int GAP_BITS = 3;

	localparam int GAP_CLKS = CLKS_PER_BIT * GAP_BITS;

endpackage

`default_nettype wire

// File: source/frame_pkg.sv
`default_nettype none

package frame_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Protocol bytes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [7:0] MARKER   = 8'hA5;
	localparam logic [7:0] FLAG_MIN = 8'h10; // Inclusive.
	localparam logic [7:0] FLAG_MAX = 8'h1F; // Inclusive.

	// Byte numbers within a frame, counted from one.
	localparam int POS_MARKER = 1;
	localparam int POS_FLAG   = 2;
	localparam int POS_ADDR   = 3;
	localparam int POS_LEN    = 4;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CRC-16, MSB first
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [15:0] CRC_POLY = 16'h1021;
	localparam logic [15:0] CRC_INIT = 16'hFFFF;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Status word
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int STATUS_W = 7;

	localparam int ST_OK  = 0;
	localparam int ST_MRK = 1;
	localparam int ST_FLG = 2;
	localparam int ST_LEN = 3;
	localparam int ST_PAR = 4; // Also set by a low stop bit.
	localparam int ST_CRC = 5;
	localparam int ST_OVR = 6; // An earlier status was dropped.

endpackage

`default_nettype wire

// File: source/uart_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_byte_rx (
	input wire clk,
	input wire N_RST_BY_TICK_AFTER_MSG_END,
	input wire rxd,
	output logic [7:0] byte_data,
	output logic byte_valid,
	output logic parity_err
);

	import link_pkg::*;

	typedef enum logic [2:0] {s_idle, s_start, s_data, s_par, s_stop} state_t;

	state_t state;
	logic rx_m;
	logic rx_s;
	logic [$clog2(CLKS_PER_BIT)-1:0] bit_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shreg;
	logic par_bit;
	logic at_mid;

	always_ff @(posedge clk or negedge N_RST_BY_TICK_AFTER_MSG_END)
	begin
		if (!N_RST_BY_TICK_AFTER_MSG_END)
		begin
			rx_m <= 1'b1;
			rx_s <= 1'b1;
		end
		else
		begin
			rx_m <= rxd;
			rx_s <= rx_m;
		end
	end

	// Half a bit in the start phase, a full bit after that.
	assign at_mid = (state == s_start) ?
		(bit_cnt == $bits(bit_cnt)'(CLKS_PER_BIT / 2 - 1)) :
		(bit_cnt == $bits(bit_cnt)'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or negedge N_RST_BY_TICK_AFTER_MSG_END)
	begin
		if (!N_RST_BY_TICK_AFTER_MSG_END)
		begin
			state <= s_idle;
			bit_cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
			parity_err <= 1'b0;
		end
		else
		begin
			byte_valid <= 1'b0;
			if (state == s_idle)
			begin
				if (!rx_s)
				begin
					state <= s_start;
					bit_cnt <= $bits(bit_cnt)'(2); // Synchronizer delay.
				end
			end
			else if (!at_mid)
				bit_cnt <= bit_cnt + 1'b1;
			else
			begin
				bit_cnt <= '0;
				case (state)
					s_start: begin
						state <= rx_s ? s_idle : s_data; // False start when high.
						bit_idx <= '0;
					end
					s_data: begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= s_par;
					end
					s_par: state <= s_stop;
					default: begin
						byte_valid <= 1'b1;
						parity_err <= (^shreg ^ par_bit) | ~rx_s;
						state <= s_idle;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (at_mid && state == s_data)
			shreg <= {rx_s, shreg[7:1]}; // LSB first.
		if (at_mid && state == s_par)
			par_bit <= rx_s;
	end

	assign byte_data = shreg;

endmodule

`default_nettype wire

// File: source/crc16_calc.sv
`timescale 1ns/1ps
`default_nettype none

module crc16_calc (
	input wire clk,
	input wire N_RST_BY_TICK_AFTER_MSG_END,
	input wire [7:0] byte_data,
	input wire byte_valid,
	input wire crc_hold,
	input wire crc_clr,
	output logic [15:0] crc_value
);

	import frame_pkg::*;

	function automatic logic [15:0] crc_step(input logic [15:0] c_in, input logic [7:0] d);
		logic [15:0] c;
		c = c_in ^ {d, 8'h00};
		for (int i = 0; i < 8; i++)
		begin
			c = c[15] ? ((c << 1) ^ CRC_POLY) : (c << 1);
		end
		return c;
	endfunction

	always_ff @(posedge clk or negedge N_RST_BY_TICK_AFTER_MSG_END)
	begin
		if (!N_RST_BY_TICK_AFTER_MSG_END)
			crc_value <= CRC_INIT;
		else if (crc_clr)
			crc_value <= CRC_INIT; // Wins over a byte in the same cycle.
		else if (byte_valid && !crc_hold)
			crc_value <= crc_step(crc_value, byte_data);
	end

endmodule

`default_nettype wire

// File: source/frame_gap_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_gap_timer (
	input wire clk,
	input wire N_RST_BY_TICK_AFTER_MSG_END,
	input wire byte_valid,
	input wire rxd,
	output logic frame_end
);

	import link_pkg::*;

	logic armed;
	logic [$clog2(GAP_CLKS)-1:0] idle_cnt;
	logic [1:0] rx_sync;

	always_ff @(posedge clk or negedge N_RST_BY_TICK_AFTER_MSG_END)
	begin
		if (!N_RST_BY_TICK_AFTER_MSG_END)
		begin
			armed <= 1'b0;
			idle_cnt <= '0;
			rx_sync <= 2'b11;
			frame_end <= 1'b0;
		end
		else
		begin
			rx_sync <= {rx_sync[0], rxd};
			frame_end <= 1'b0;
			if (byte_valid)
			begin
				armed <= 1'b1;
				idle_cnt <= $bits(idle_cnt)'(1); // The byte cycle counts as one.
			end
			else if (armed)
			begin
				if (!rx_sync[1])
				begin
					idle_cnt <= '0; // Line busy again.
					armed <= 1'b0; // Next byte_valid rearms.
				end
				else if (idle_cnt == $bits(idle_cnt)'(GAP_CLKS - 1))
				begin
					frame_end <= 1'b1;
					armed <= 1'b0;
				end
				else
					idle_cnt <= idle_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/frame_checker.sv
`timescale 1ns/1ps
`default_nettype none

module frame_checker (
	input wire clk,
	input wire N_RST_BY_TICK_AFTER_MSG_END,
	input wire [7:0] byte_data,
	input wire byte_valid,
	input wire parity_err,
	input wire [15:0] crc_value,
	input wire frame_end,
	input wire status_ack,
	output logic crc_hold,
	output logic crc_clr,
	output logic status_req,
	output logic [frame_pkg::STATUS_W-1:0] status,
	output logic [7:0] rx_flag,
	output logic [7:0] rx_len
);

	import frame_pkg::*;

	logic [8:0] b_cnt; // Bytes taken so far in this frame.
	logic [8:0] pos;
	logic [7:0] rx_n;
	logic [7:0] flag_cap;
	logic mrk_right;
	logic flg_right;
	logic par_seen;
	logic crc_h_right;
	logic crc_l_right;
	logic ovr_pend;
	logic accept;
	logic [STATUS_W-1:0] st_next;

	assign pos = b_cnt + 9'd1; // Position of the byte now on byte_data.
	assign crc_hold = (b_cnt >= {1'b0, rx_n} + 9'd4);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Per-frame field checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge N_RST_BY_TICK_AFTER_MSG_END)
	begin
		if (!N_RST_BY_TICK_AFTER_MSG_END)
		begin
			b_cnt <= '0;
			rx_n <= '0;
			mrk_right <= 1'b0;
			flg_right <= 1'b0;
			par_seen <= 1'b0;
			crc_h_right <= 1'b0;
			crc_l_right <= 1'b0;
		end
		else if (frame_end)
		begin
			b_cnt <= '0;
			rx_n <= '0;
			mrk_right <= 1'b0;
			flg_right <= 1'b0;
			par_seen <= 1'b0;
			crc_h_right <= 1'b0;
			crc_l_right <= 1'b0;
		end
		else if (byte_valid)
		begin
			if (b_cnt != '1)
				b_cnt <= pos;
			if (pos == 9'(POS_LEN))
				rx_n <= byte_data;
			if (pos == 9'(POS_MARKER) && byte_data == MARKER)
				mrk_right <= 1'b1;
			if (pos == 9'(POS_FLAG) && byte_data >= FLAG_MIN && byte_data <= FLAG_MAX)
				flg_right <= 1'b1;
			if (parity_err)
				par_seen <= 1'b1;
			if (pos == {1'b0, rx_n} + 9'd5 && byte_data == crc_value[15:8])
				crc_h_right <= 1'b1;
			if (pos == {1'b0, rx_n} + 9'd6 && byte_data == crc_value[7:0])
				crc_l_right <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (byte_valid && pos == 9'(POS_FLAG))
			flag_cap <= byte_data;
	end

	always_comb
	begin
		st_next = '0;
		st_next[ST_MRK] = ~mrk_right;
		st_next[ST_FLG] = ~flg_right;
		st_next[ST_LEN] = (b_cnt != {1'b0, rx_n} + 9'd6);
		st_next[ST_PAR] = par_seen;
		st_next[ST_CRC] = ~(crc_h_right & crc_l_right); // Missed or never came.
		st_next[ST_OK] = ~|st_next;
		st_next[ST_OVR] = ovr_pend;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Status handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Host must have finished the previous four-phase cycle.
	assign accept = frame_end & ~status_req & ~status_ack;

	always_ff @(posedge clk or negedge N_RST_BY_TICK_AFTER_MSG_END)
	begin
		if (!N_RST_BY_TICK_AFTER_MSG_END)
		begin
			status_req <= 1'b0;
			crc_clr <= 1'b0;
			ovr_pend <= 1'b0;
		end
		else
		begin
			crc_clr <= frame_end;
			if (status_req && status_ack)
				status_req <= 1'b0;
			if (accept)
			begin
				status_req <= 1'b1;
				ovr_pend <= 1'b0;
			end
			else if (frame_end)
				ovr_pend <= 1'b1; // This frame's status is lost.
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			status <= st_next;
			rx_flag <= flag_cap;
			rx_len <= rx_n;
		end
	end

endmodule

`default_nettype wire

// File: source/frame_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_rx_top (
	input wire clk,
	input wire N_RST_BY_TICK_AFTER_MSG_END,
	input wire rxd,
	input wire status_ack,
	output logic status_req,
	output logic [frame_pkg::STATUS_W-1:0] status,
	output logic [7:0] rx_flag,
	output logic [7:0] rx_len
);

	logic [7:0] byte_data;
	logic byte_valid;
	logic parity_err;
	logic crc_hold;
	logic crc_clr;
	logic [15:0] crc_value;
	logic frame_end;

	uart_byte_rx uart_byte_rx_i (
		.clk(clk),
		.N_RST_BY_TICK_AFTER_MSG_END(N_RST_BY_TICK_AFTER_MSG_END),
		.rxd(rxd),
		.byte_data(byte_data),
		.byte_valid(byte_valid),
		.parity_err(parity_err)
	);

	crc16_calc crc16_calc_i (
		.clk(clk),
		.N_RST_BY_TICK_AFTER_MSG_END(N_RST_BY_TICK_AFTER_MSG_END),
		.byte_data(byte_data),
		.byte_valid(byte_valid),
		.crc_hold(crc_hold),
		.crc_clr(crc_clr),
		.crc_value(crc_value)
	);

	frame_gap_timer frame_gap_timer_i (
		.clk(clk),
		.N_RST_BY_TICK_AFTER_MSG_END(N_RST_BY_TICK_AFTER_MSG_END),
		.byte_valid(byte_valid),
		.rxd(rxd),
		.frame_end(frame_end)
	);

	frame_checker frame_checker_i (
		.clk(clk),
		.N_RST_BY_TICK_AFTER_MSG_END(N_RST_BY_TICK_AFTER_MSG_END),
		.byte_data(byte_data),
		.byte_valid(byte_valid),
		.parity_err(parity_err),
		.crc_value(crc_value),
		.frame_end(frame_end),
		.status_ack(status_ack),
		.crc_hold(crc_hold),
		.crc_clr(crc_clr),
		.status_req(status_req),
		.status(status),
		.rx_flag(rx_flag),
		.rx_len(rx_len)
	);

endmodule

`default_nettype wire

// File: verif/frame_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frame_rx_tb;

	import link_pkg::*;
	import frame_pkg::*;

	localparam int REQ_TIMEOUT = 2000; // Clocks.
	localparam int ACK_TIMEOUT = 50;

	logic clk;
	logic N_RST_BY_TICK_AFTER_MSG_END;
	logic rxd;
	logic status_ack;
	wire status_req;
	wire [STATUS_W-1:0] status;
	wire [7:0] rx_flag;
	wire [7:0] rx_len;

	integer seed;
	logic [7:0] tx_q[$]; // Bytes of the next frame, marker first.

	frame_rx_top frame_rx_top_i (
		.clk(clk),
		.N_RST_BY_TICK_AFTER_MSG_END(N_RST_BY_TICK_AFTER_MSG_END),
		.rxd(rxd),
		.status_ack(status_ack),
		.status_req(status_req),
		.status(status),
		.rx_flag(rx_flag),
		.rx_len(rx_len)
	);

	always #5 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks and helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic abort_run;
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			abort_run();
		end
	endtask

	// CRC-16 over the first count bytes of tx_q, one bit at a time.
	function automatic logic [15:0] crc_ref(input int count);
		logic [15:0] c;
		logic fb;
		c = CRC_INIT;
		for (int i = 0; i < count; i++)
		begin
			for (int j = 7; j >= 0; j--)
			begin
				fb = c[15] ^ tx_q[i][j];
				c = {c[14:0], 1'b0};
				if (fb)
					c = c ^ CRC_POLY;
			end
		end
		return c;
	endfunction

	task automatic build_frame(input logic [7:0] marker, input logic [7:0] flag,
		input logic [7:0] n);
		logic [15:0] crc;
		tx_q.delete();
		tx_q.push_back(marker);
		tx_q.push_back(flag);
		tx_q.push_back(8'($random(seed))); // Address.
		tx_q.push_back(n);
		for (int i = 0; i < int'(n); i++)
			tx_q.push_back(8'($random(seed)));
		crc = crc_ref(tx_q.size());
		tx_q.push_back(crc[15:8]);
		tx_q.push_back(crc[7:0]);
	endtask

	task automatic hold_bit(input logic v);
		rxd = v;
		repeat (CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic send_byte(input logic [7:0] b, input logic bad_par);
		hold_bit(1'b0); // Start.
		for (int i = 0; i < 8; i++)
			hold_bit(b[i]);
		hold_bit(^b ^ bad_par); // Even parity.
		hold_bit(1'b1);
	endtask

	// Sends tx_q; bad_idx picks one byte with wrong parity, or -1 for none.
	task automatic send_frame(input int bad_idx);
		for (int i = 0; i < tx_q.size(); i++)
			send_byte(tx_q[i], i == bad_idx);
		rxd = 1'b1;
		repeat ((GAP_BITS + 1) * CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic wait_req;
		int t;
		t = 0;
		while (status_req !== 1'b1 && t < REQ_TIMEOUT)
		begin
			@(negedge clk);
			t++;
		end
		if (status_req !== 1'b1)
		begin
			$display("Timeout while waiting for status_req to rise");
			abort_run();
		end
	endtask

	task automatic wait_status(input logic [STATUS_W-1:0] exp_st,
		input logic [7:0] exp_flag, input logic [7:0] exp_len);
		int t;
		wait_req();
		check("status", 32'(status), 32'(exp_st));
		check("rx_flag", 32'(rx_flag), 32'(exp_flag));
		check("rx_len", 32'(rx_len), 32'(exp_len));
		status_ack = 1'b1;
		t = 0;
		while (status_req !== 1'b0 && t < ACK_TIMEOUT)
		begin
			@(negedge clk);
			t++;
		end
		if (status_req !== 1'b0)
		begin
			$display("Timeout while waiting for status_req to fall after ack");
			abort_run();
		end
		status_ack = 1'b0;
		@(negedge clk);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_valid_frame;
		build_frame(MARKER, 8'h13, 8'd5);
		send_frame(-1);
		wait_status(7'(1 << ST_OK), 8'h13, 8'd5);
	endtask

	task automatic test_header_errors;
		build_frame(8'h5A, 8'h11, 8'd5);
		send_frame(-1);
		wait_status(7'(1 << ST_MRK), 8'h11, 8'd5);
		build_frame(MARKER, 8'h20, 8'd5);
		send_frame(-1);
		wait_status(7'(1 << ST_FLG), 8'h20, 8'd5);
	endtask

	task automatic test_parity_error;
		build_frame(MARKER, 8'h1F, 8'd5);
		send_frame(6); // Third data byte.
		wait_status(7'(1 << ST_PAR), 8'h1F, 8'd5);
	endtask

	task automatic test_crc_and_length;
		logic [15:0] crc9;
		build_frame(MARKER, 8'h12, 8'd5);
		tx_q[tx_q.size() - 1] = tx_q[tx_q.size() - 1] ^ 8'h01;
		send_frame(-1);
		wait_status(7'(1 << ST_CRC), 8'h12, 8'd5);

		// Extra byte lands where the CRC high byte belongs, made to differ from it.
		build_frame(MARKER, 8'h10, 8'd5);
		crc9 = crc_ref(9);
		tx_q.insert(9, crc9[15:8] ^ 8'hFF);
		send_frame(-1);
		wait_status(7'((1 << ST_LEN) | (1 << ST_CRC)), 8'h10, 8'd5);
	endtask

	task automatic test_back_pressure;
		build_frame(MARKER, 8'h14, 8'd3);
		send_frame(-1);
		wait_req();
		build_frame(MARKER, 8'h15, 8'd4); // Dropped, req still up.
		send_frame(-1);
		wait_status(7'(1 << ST_OK), 8'h14, 8'd3);

		build_frame(MARKER, 8'h16, 8'd5);
		send_frame(-1);
		wait_status(7'((1 << ST_OK) | (1 << ST_OVR)), 8'h16, 8'd5);

		build_frame(MARKER, 8'h17, 8'd2);
		send_frame(-1);
		wait_status(7'(1 << ST_OK), 8'h17, 8'd2);
	endtask

	initial
	begin
		seed = 32'hb94c;
		clk = 1'b0;
		N_RST_BY_TICK_AFTER_MSG_END = 1'b0;
		rxd = 1'b1; // Line idle.
		status_ack = 1'b0;
		repeat (5) @(negedge clk);
		N_RST_BY_TICK_AFTER_MSG_END = 1'b1;
		repeat (2) @(negedge clk);

		test_valid_frame();
		test_header_errors();
		test_parity_error();
		test_crc_and_length();
		test_back_pressure();

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
source/link_pkg.sv
source/frame_pkg.sv
source/uart_byte_rx.sv
source/crc16_calc.sv
source/frame_gap_timer.sv
source/frame_checker.sv
source/frame_rx_top.sv
verif/frame_rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the frame receiver testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f src.f \
	--top-module frame_rx_tb -o frame_rx_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/frame_rx_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
